// File: hdl/ctrl_pkg.sv
package ctrl_pkg;

	// ========================================
	// Sizes
	// ========================================
	localparam int NUM_PLAYERS = 2;
	localparam int JOY_W = 16;
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// Shift clock half period in clk_53p6 cycles
	localparam int DB15_HALF_BIT = 4;
	// Player 1 first, MSB first, then player 2
	localparam int DB15_FRAME_BITS = 32;

	// ========================================
	// Register map
	// ========================================
	localparam logic [APB_AW-1:0] ADDR_DIP = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_CTRL = 8'h04;
	localparam logic [APB_AW-1:0] ADDR_PLAYERS = 8'h08;
	localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h0C;

	// Trackball title, DB15 pads make no sense here
	localparam logic [7:0] GAME_COUNTRY_CLUB = 8'h14;

	// ========================================
	// Cabinet word, every bit active low
	// ========================================
	localparam logic [JOY_W-1:0] CAB_IDLE = '1;
	localparam int CAB_COIN = 0;
	localparam int CAB_START = 1;
	localparam int CAB_BTN1 = 2;
	localparam int CAB_BTN2 = 3;
	// Bits 4 to 8 and 14 to 15 stay high
	localparam int CAB_SERVICE = 9;
	localparam int CAB_LEFT = 10;
	localparam int CAB_RIGHT = 11;
	localparam int CAB_DOWN = 12;
	localparam int CAB_UP = 13;

	// Raw pad word, pressed is 1 in both views
	typedef union packed {
		struct packed {
			logic [3:0] spare;
			logic select;
			logic start;
			logic f;
			logic e;
			logic d;
			logic c;
			logic b;
			logic a;
			logic up;
			logic down;
			logic left;
			logic right;
		} db15;
		struct packed {
			logic [5:0] spare;
			logic pause;
			logic service;
			logic coin;
			logic start;
			logic button2;
			logic button1;
			logic up;
			logic down;
			logic left;
			logic right;
		} usb;
	} joy_word_u;

endpackage

// File: hdl/db15_reader.sv
`timescale 1ns/1ps

module db15_reader (
	input  logic                clk_53p6,
	input  logic                rst_n,
	input  logic                joy_data,
	output logic                joy_clk,
	output logic                joy_load,
	output ctrl_pkg::joy_word_u db15_word_0,
	output ctrl_pkg::joy_word_u db15_word_1,
	output logic                frame_done
);
	import ctrl_pkg::*;

	// Sequencer state
	logic [$clog2(DB15_HALF_BIT)-1:0] half_cnt;
	logic half_hi;
	// Slot 0 is the load period, slots 1..32 carry data
	logic [$clog2(DB15_FRAME_BITS+1)-1:0] bit_cnt;
	logic [DB15_FRAME_BITS-1:0] shift_q;
	logic [DB15_FRAME_BITS-1:0] shift_next;
	logic half_end;
	logic data_slot;
	logic sample;
	logic last_bit;

	assign half_end = int'(half_cnt) == DB15_HALF_BIT - 1;
	assign data_slot = bit_cnt != '0;
	// First cycle of the high half, same edge that raises joy_clk
	assign sample = data_slot && half_hi && (half_cnt == '0);
	assign last_bit = int'(bit_cnt) == DB15_FRAME_BITS;
	// New bit enters at the LSB
	assign shift_next = {shift_q[DB15_FRAME_BITS-2:0], joy_data};

	// ========================================
	// Half period and bit counters
	// ========================================
	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			half_cnt <= '0;
			half_hi <= 1'b0;
			bit_cnt <= '0;
		end else if (half_end) begin
			half_cnt <= '0;
			half_hi <= ~half_hi;
			// Advance slot at the end of the high half
			if (half_hi) begin
				if (last_bit)
					bit_cnt <= '0;
				else
					bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// Pin drivers, one cycle behind the counters
	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			joy_load <= 1'b1;
			joy_clk <= 1'b0;
		end else begin
			joy_load <= data_slot;
			joy_clk <= data_slot && half_hi;
		end
	end

	// Serial capture
	always_ff @(posedge clk_53p6) begin
		if (sample)
			shift_q <= shift_next;
	end

	// ========================================
	// Frame split
	// ========================================
	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			db15_word_0 <= '0;
			db15_word_1 <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= sample && last_bit;
			// Upper half arrived first, so it is player 1
			if (sample && last_bit) begin
				db15_word_0 <= shift_next[DB15_FRAME_BITS-1:JOY_W];
				db15_word_1 <= shift_next[JOY_W-1:0];
			end
		end
	end

endmodule

// File: hdl/player_mapper.sv
`timescale 1ns/1ps

module player_mapper (
	input  logic                       clk_53p6,
	input  logic                       rst_n,
	input  logic                       snac_en,
	input  ctrl_pkg::joy_word_u        db15_word,
	input  ctrl_pkg::joy_word_u        usb_word,
	output logic [ctrl_pkg::JOY_W-1:0] cab_word,
	output logic                       pause
);
	import ctrl_pkg::*;

	// Decoded controls, pressed is 1
	logic up;
	logic down;
	logic left;
	logic right;
	logic btn1;
	logic btn2;
	logic start;
	logic coin;
	logic service;
	logic pause_d;
	logic [JOY_W-1:0] cab_next;

	// Source select
	always_comb begin
		if (snac_en) begin
			up = db15_word.db15.up;
			down = db15_word.db15.down;
			left = db15_word.db15.left;
			right = db15_word.db15.right;
			// NeoGeo style pad, B and C are the fire buttons
			btn1 = db15_word.db15.b;
			btn2 = db15_word.db15.c;
			start = db15_word.db15.start;
			coin = db15_word.db15.select;
			// Combos stand in for missing buttons
			service = db15_word.db15.select & db15_word.db15.b;
			pause_d = db15_word.db15.select & db15_word.db15.a;
		end else begin
			up = usb_word.usb.up;
			down = usb_word.usb.down;
			left = usb_word.usb.left;
			right = usb_word.usb.right;
			btn1 = usb_word.usb.button1;
			btn2 = usb_word.usb.button2;
			start = usb_word.usb.start;
			coin = usb_word.usb.coin;
			service = usb_word.usb.service;
			pause_d = usb_word.usb.pause;
		end
	end

	// Cabinet word, unused bits stay high
	always_comb begin
		cab_next = CAB_IDLE;
		cab_next[CAB_COIN] = ~coin;
		cab_next[CAB_START] = ~start;
		cab_next[CAB_BTN1] = ~btn1;
		cab_next[CAB_BTN2] = ~btn2;
		cab_next[CAB_SERVICE] = ~service;
		cab_next[CAB_LEFT] = ~left;
		cab_next[CAB_RIGHT] = ~right;
		cab_next[CAB_DOWN] = ~down;
		cab_next[CAB_UP] = ~up;
	end

	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			cab_word <= CAB_IDLE;
			pause <= 1'b0;
		end else begin
			cab_word <= cab_next;
			pause <= pause_d;
		end
	end

endmodule

// File: hdl/cabinet_regs.sv
`timescale 1ns/1ps

module cabinet_regs (
	input  logic                             clk_53p6,
	input  logic                             rst_n,
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [ctrl_pkg::APB_AW-1:0]      paddr,
	input  logic [ctrl_pkg::APB_DW-1:0]      pwdata,
	output logic [ctrl_pkg::APB_DW-1:0]      prdata,
	output logic                             pready,
	output logic                             pslverr,
	input  logic [ctrl_pkg::JOY_W-1:0]       cab_word_0,
	input  logic [ctrl_pkg::JOY_W-1:0]       cab_word_1,
	input  logic                             pause_0,
	input  logic                             pause_1,
	output logic [ctrl_pkg::NUM_PLAYERS-1:0] snac_en,
	output logic [15:0]                      dsw,
	output logic [ctrl_pkg::JOY_W-1:0]       player_1,
	output logic [ctrl_pkg::JOY_W-1:0]       player_2,
	output logic                             pause_req
);
	import ctrl_pkg::*;

	// Configuration
	logic [15:0] dip_q;
	logic [NUM_PLAYERS-1:0] snac_sel_q;
	logic [7:0] game_q;
	// Collected status
	logic [NUM_PLAYERS-1:0] pause_q;
	logic setup;
	logic access;
	logic mapped;
	logic read_only;

	assign setup = psel && !penable;
	assign access = psel && penable;
	assign mapped = (paddr == ADDR_DIP) || (paddr == ADDR_CTRL) ||
		(paddr == ADDR_PLAYERS) || (paddr == ADDR_STATUS);
	assign read_only = (paddr == ADDR_PLAYERS) || (paddr == ADDR_STATUS);

	// No wait states
	assign pready = access;

	// ========================================
	// APB write side
	// ========================================
	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			dip_q <= '0;
			snac_sel_q <= '0;
			game_q <= '0;
		end else if (access && pwrite) begin
			if (paddr == ADDR_DIP)
				dip_q <= pwdata[15:0];
			if (paddr == ADDR_CTRL) begin
				snac_sel_q <= pwdata[NUM_PLAYERS-1:0];
				game_q <= pwdata[15:8];
			end
		end
	end

	// Error flag decided in setup, shown in access
	always_ff @(posedge clk_53p6) begin
		if (!rst_n)
			pslverr <= 1'b0;
		else
			pslverr <= setup && (!mapped || (pwrite && read_only));
	end

	// Read mux, quiet outside read accesses
	always_comb begin
		prdata = '0;
		if (access && !pwrite) begin
			case (paddr)
				ADDR_DIP: prdata = APB_DW'(dip_q);
				ADDR_CTRL: prdata = APB_DW'({game_q, 6'b0, snac_sel_q});
				ADDR_PLAYERS: prdata = APB_DW'({player_2, player_1});
				ADDR_STATUS: prdata = APB_DW'(pause_q);
				default: prdata = '0;
			endcase
		end
	end

	// ========================================
	// Player side
	// ========================================
	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			snac_en <= '0;
			player_1 <= CAB_IDLE;
			player_2 <= CAB_IDLE;
			pause_q <= '0;
			pause_req <= 1'b0;
		end else begin
			// Country Club is trackball only, DB15 stays off
			if (game_q == GAME_COUNTRY_CLUB)
				snac_en <= '0;
			else
				snac_en <= snac_sel_q;
			player_1 <= cab_word_0;
			player_2 <= cab_word_1;
			pause_q <= {pause_1, pause_0};
			pause_req <= pause_0 | pause_1;
		end
	end

	assign dsw = dip_q;

endmodule

// File: hdl/ctrl_top.sv
`timescale 1ns/1ps

module ctrl_top (
	input  logic                        clk_53p6,
	input  logic                        rst_n,
	// APB slave
	input  logic                        psel,
	input  logic                        penable,
	input  logic                        pwrite,
	input  logic [ctrl_pkg::APB_AW-1:0] paddr,
	input  logic [ctrl_pkg::APB_DW-1:0] pwdata,
	output logic [ctrl_pkg::APB_DW-1:0] prdata,
	output logic                        pready,
	output logic                        pslverr,
	// User port
	input  logic                        joy_data,
	output logic                        joy_clk,
	output logic                        joy_load,
	// USB gamepads
	input  logic [ctrl_pkg::JOY_W-1:0]  usb_joy_0,
	input  logic [ctrl_pkg::JOY_W-1:0]  usb_joy_1,
	// Cabinet side
	output logic [15:0]                 dsw,
	output logic [ctrl_pkg::JOY_W-1:0]  player_1,
	output logic [ctrl_pkg::JOY_W-1:0]  player_2,
	output logic                        pause_req
);
	import ctrl_pkg::*;

	joy_word_u db15_w [NUM_PLAYERS];
	joy_word_u usb_w [NUM_PLAYERS];
	logic [JOY_W-1:0] cab_w [NUM_PLAYERS];
	logic [NUM_PLAYERS-1:0] pause_w;
	logic [NUM_PLAYERS-1:0] snac_en;
	logic frame_done;

	assign usb_w[0] = usb_joy_0;
	assign usb_w[1] = usb_joy_1;

	// Serial DB15 front end
	db15_reader u_reader (
		.clk_53p6   (clk_53p6),
		.rst_n      (rst_n),
		.joy_data   (joy_data),
		.joy_clk    (joy_clk),
		.joy_load   (joy_load),
		.db15_word_0(db15_w[0]),
		.db15_word_1(db15_w[1]),
		.frame_done (frame_done)
	);

	// One mapper per player
	for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_player
		player_mapper u_mapper (
			.clk_53p6 (clk_53p6),
			.rst_n    (rst_n),
			.snac_en  (snac_en[i]),
			.db15_word(db15_w[i]),
			.usb_word (usb_w[i]),
			.cab_word (cab_w[i]),
			.pause    (pause_w[i])
		);
	end

	cabinet_regs u_regs (
		.clk_53p6  (clk_53p6),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.cab_word_0(cab_w[0]),
		.cab_word_1(cab_w[1]),
		.pause_0   (pause_w[0]),
		.pause_1   (pause_w[1]),
		.snac_en   (snac_en),
		.dsw       (dsw),
		.player_1  (player_1),
		.player_2  (player_2),
		.pause_req (pause_req)
	);

endmodule

// File: dv/ctrl_tb_sva.sv
`timescale 1ns/1ps

module ctrl_tb_sva (
	input logic clk_53p6,
	input logic rst_n,
	input logic joy_clk,
	input logic joy_load,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic frame_done
);

	// Cycles since the last frame strobe
	logic [8:0] gap_cnt;
	logic seen_frame;

	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			gap_cnt <= '0;
			seen_frame <= 1'b0;
		end else if (frame_done) begin
			gap_cnt <= '0;
			seen_frame <= 1'b1;
		end else begin
			gap_cnt <= gap_cnt + 9'd1;
		end
	end

	// ========================================
	// User port
	// ========================================
	a_load_clk: assert property (@(posedge clk_53p6) disable iff (!rst_n)
		!joy_load |-> !joy_clk)
		else $error("joy_clk high while joy_load is low");

	// 33 bit periods of 8 cycles
	a_frame_period: assert property (@(posedge clk_53p6) disable iff (!rst_n)
		seen_frame |-> frame_done == (gap_cnt == 9'd263))
		else $error("frame_done spacing is not 264 cycles");

	// ========================================
	// APB
	// ========================================
	a_no_wait: assert property (@(posedge clk_53p6) disable iff (!rst_n)
		psel && penable |-> pready)
		else $error("pready low in an access cycle");

	a_err_access: assert property (@(posedge clk_53p6) disable iff (!rst_n)
		pslverr |-> psel && penable)
		else $error("pslverr outside an access cycle");

endmodule

// File: dv/ctrl_tb.sv
`timescale 1ns/1ps

module ctrl_tb;
	import ctrl_pkg::*;

	// Tests take about 4300 cycles, limit is roughly four times that
	localparam int MAX_CYCLES = 20000;

	logic clk_53p6;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic joy_data;
	logic joy_clk;
	logic joy_load;
	logic [JOY_W-1:0] usb_joy_0;
	logic [JOY_W-1:0] usb_joy_1;
	logic [15:0] dsw;
	logic [JOY_W-1:0] player_1;
	logic [JOY_W-1:0] player_2;
	logic pause_req;

	int seed;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int chk_cnt = 0;
	int cmp_err_cnt = 0;
	int cmp_cnt = 0;
	int test_num = 0;
	int test_base = 0;
	string test_name;
	// Words the serial model sends, player 1 then player 2
	logic [15:0] tx_word_0;
	logic [15:0] tx_word_1;
	// Expected outputs handed to the comparing process
	logic [15:0] exp_p1;
	logic [15:0] exp_p2;
	logic exp_pause;
	int cmp_req = 0;
	int cmp_ack = 0;

	ctrl_top dut (
		.clk_53p6 (clk_53p6),
		.rst_n    (rst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.joy_data (joy_data),
		.joy_clk  (joy_clk),
		.joy_load (joy_load),
		.usb_joy_0(usb_joy_0),
		.usb_joy_1(usb_joy_1),
		.dsw      (dsw),
		.player_1 (player_1),
		.player_2 (player_2),
		.pause_req(pause_req)
	);

	bind ctrl_top ctrl_tb_sva u_sva (
		.clk_53p6  (clk_53p6),
		.rst_n     (rst_n),
		.joy_clk   (joy_clk),
		.joy_load  (joy_load),
		.psel      (psel),
		.penable   (penable),
		.pready    (pready),
		.pslverr   (pslverr),
		.frame_done(frame_done)
	);

	initial begin
		clk_53p6 = 1'b0;
		forever #5 clk_53p6 = ~clk_53p6;
	end

	// Run limit
	always @(posedge clk_53p6) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycle_cnt);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ========================================
	// DB15 pad model
	// ========================================
	initial begin : serial_model
		logic [31:0] frame_bits;
		int bit_idx;
		logic clk_prev;
		joy_data = 1'b0;
		frame_bits = '0;
		bit_idx = 0;
		clk_prev = 1'b0;
		forever begin
			@(posedge clk_53p6);
			#1;
			// Latch words during load, MSB goes out first
			if (!joy_load) begin
				frame_bits = {tx_word_0, tx_word_1};
				bit_idx = 0;
				joy_data = frame_bits[31];
			end else if (clk_prev && !joy_clk) begin
				// Next bit right after the falling shift clock
				bit_idx++;
				if (bit_idx < 32)
					joy_data = frame_bits[31 - bit_idx];
			end
			clk_prev = joy_clk;
		end
	end

	// Expected cabinet word in bits 15:0, pause in bit 16
	function automatic logic [16:0] cab_ref(input logic [15:0] db_w, input logic [15:0] usb_w,
		input logic snac, input logic [7:0] game);
		logic [15:0] cab;
		logic rt;
		logic lf;
		logic dn;
		logic up;
		logic b1;
		logic b2;
		logic st;
		logic cn;
		logic sv;
		logic p;
		if (snac && game != GAME_COUNTRY_CLUB) begin
			rt = db_w[0];
			lf = db_w[1];
			dn = db_w[2];
			up = db_w[3];
			b1 = db_w[5];
			b2 = db_w[6];
			st = db_w[10];
			cn = db_w[11];
			// Select combos
			sv = db_w[11] & db_w[5];
			p = db_w[11] & db_w[4];
		end else begin
			rt = usb_w[0];
			lf = usb_w[1];
			dn = usb_w[2];
			up = usb_w[3];
			b1 = usb_w[4];
			b2 = usb_w[5];
			st = usb_w[6];
			cn = usb_w[7];
			sv = usb_w[8];
			p = usb_w[9];
		end
		cab = 16'hFFFF;
		cab[0] = ~cn;
		cab[1] = ~st;
		cab[2] = ~b1;
		cab[3] = ~b2;
		cab[9] = ~sv;
		cab[10] = ~lf;
		cab[11] = ~rt;
		cab[12] = ~dn;
		cab[13] = ~up;
		return {p, cab};
	endfunction

	// Comparing process, woken by a request count
	always begin
		wait (cmp_req != cmp_ack);
		cmp_cnt++;
		assert (player_1 === exp_p1) else begin
			$display("FAIL @%0t: player_1 %h, expected %h", $time, player_1, exp_p1);
			cmp_err_cnt++;
		end
		assert (player_2 === exp_p2) else begin
			$display("FAIL @%0t: player_2 %h, expected %h", $time, player_2, exp_p2);
			cmp_err_cnt++;
		end
		assert (pause_req === exp_pause) else begin
			$display("FAIL @%0t: pause_req %b, expected %b", $time, pause_req, exp_pause);
			cmp_err_cnt++;
		end
		cmp_ack = cmp_req;
	end

	// ========================================
	// Helper tasks
	// ========================================
	task automatic step(input int n);
		repeat (n) @(posedge clk_53p6);
		#1;
	endtask

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		assert (got === exp) else begin
			$display("FAIL @%0t: %s is %h, expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic compare_players(input logic [15:0] db0, input logic [15:0] db1,
		input logic [15:0] usb0, input logic [15:0] usb1, input logic snac,
		input logic [7:0] game);
		logic [16:0] r1;
		logic [16:0] r2;
		r1 = cab_ref(db0, usb0, snac, game);
		r2 = cab_ref(db1, usb1, snac, game);
		exp_p1 = r1[15:0];
		exp_p2 = r2[15:0];
		exp_pause = r1[16] | r2[16];
		cmp_req++;
		wait (cmp_ack == cmp_req);
	endtask

	// Setup then access, no wait states
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
		input logic exp_err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		step(1);
		penable = 1'b1;
		#1;
		check_val("pready", 32'(pready), 32'd1);
		check_val("pslverr", 32'(pslverr), 32'(exp_err));
		step(1);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		input logic exp_err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		step(1);
		penable = 1'b1;
		#1;
		data = prdata;
		check_val("pready", 32'(pready), 32'd1);
		check_val("pslverr", 32'(pslverr), 32'(exp_err));
		step(1);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_frames(input int n);
		repeat (n) begin
			do step(1); while (!dut.frame_done);
		end
	endtask

	task automatic check_pause(input logic [1:0] exp_bits);
		logic [31:0] rd;
		check_val("pause_req", 32'(pause_req), 32'(|exp_bits));
		apb_read(ADDR_STATUS, rd, 1'b0);
		check_val("STATUS", rd, 32'(exp_bits));
	endtask

	task automatic begin_test(input string name);
		test_num++;
		test_name = name;
		test_base = err_cnt + cmp_err_cnt;
	endtask

	task automatic end_test;
		int n;
		n = err_cnt + cmp_err_cnt - test_base;
		if (n == 0)
			$display("Test %0d %s: passed", test_num, test_name);
		else
			$display("Test %0d %s: failed with %0d errors", test_num, test_name, n);
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin : main
		logic [31:0] rnd;
		logic [31:0] rd;
		int total;
		seed = 40;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		usb_joy_0 = '0;
		usb_joy_1 = '0;
		tx_word_0 = '0;
		tx_word_1 = '0;
		rst_n = 1'b0;
		repeat (8) @(posedge clk_53p6);
		#1;

		begin_test("reset");
		check_val("joy_load", 32'(joy_load), 32'd1);
		check_val("joy_clk", 32'(joy_clk), 32'd0);
		check_val("pslverr", 32'(pslverr), 32'd0);
		compare_players(16'h0, 16'h0, 16'h0, 16'h0, 1'b0, 8'h00);
		rst_n = 1'b1;
		step(1);
		apb_read(ADDR_DIP, rd, 1'b0);
		check_val("DIP", rd, 32'h0);
		apb_read(ADDR_CTRL, rd, 1'b0);
		check_val("CTRL", rd, 32'h0);
		end_test;

		begin_test("apb");
		rnd = $random(seed);
		apb_write(ADDR_DIP, {16'h0, rnd[15:0]}, 1'b0);
		apb_read(ADDR_DIP, rd, 1'b0);
		check_val("DIP", rd, {16'h0, rnd[15:0]});
		check_val("dsw", 32'(dsw), {16'h0, rnd[15:0]});
		apb_write(ADDR_PLAYERS, rnd, 1'b1);
		apb_write(ADDR_STATUS, rnd, 1'b1);
		// Unmapped offset
		apb_read(8'h10, rd, 1'b1);
		end_test;

		begin_test("usb path");
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			usb_joy_0 = rnd[15:0];
			usb_joy_1 = rnd[31:16];
			step(2);
			compare_players(16'h0, 16'h0, usb_joy_0, usb_joy_1, 1'b0, 8'h00);
			apb_read(ADDR_PLAYERS, rd, 1'b0);
			check_val("PLAYERS", rd, {exp_p2, exp_p1});
		end
		end_test;

		begin_test("db15 path");
		apb_write(ADDR_CTRL, 32'h0000_0003, 1'b0);
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			tx_word_0 = rnd[15:0];
			tx_word_1 = rnd[31:16];
			// Select with B on the first pass
			if (i == 0)
				tx_word_0 = tx_word_0 | 16'h0820;
			// Second frame surely carries the new words
			wait_frames(2);
			step(2);
			compare_players(tx_word_0, tx_word_1, usb_joy_0, usb_joy_1, 1'b1, 8'h00);
			if (i == 0)
				check_val("service", 32'(player_1[9]), 32'd0);
		end
		end_test;

		begin_test("country club");
		apb_write(ADDR_CTRL, 32'h0000_1403, 1'b0);
		apb_read(ADDR_CTRL, rd, 1'b0);
		check_val("CTRL", rd, 32'h0000_1403);
		step(4);
		for (int i = 0; i < 3; i++) begin
			rnd = $random(seed);
			usb_joy_0 = rnd[15:0];
			usb_joy_1 = rnd[31:16];
			tx_word_0 = ~rnd[15:0];
			tx_word_1 = ~rnd[31:16];
			wait_frames(1);
			step(2);
			compare_players(tx_word_0, tx_word_1, usb_joy_0, usb_joy_1, 1'b1,
				GAME_COUNTRY_CLUB);
		end
		end_test;

		begin_test("pause");
		apb_write(ADDR_CTRL, 32'h0000_0003, 1'b0);
		usb_joy_0 = '0;
		usb_joy_1 = '0;
		// Select with A on player 1
		tx_word_0 = 16'h0810;
		tx_word_1 = '0;
		wait_frames(2);
		step(2);
		compare_players(tx_word_0, tx_word_1, usb_joy_0, usb_joy_1, 1'b1, 8'h00);
		check_pause(2'b01);
		tx_word_0 = '0;
		wait_frames(2);
		step(2);
		compare_players(tx_word_0, tx_word_1, usb_joy_0, usb_joy_1, 1'b1, 8'h00);
		check_pause(2'b00);
		// Back to USB, pause on player 2
		apb_write(ADDR_CTRL, 32'h0, 1'b0);
		step(4);
		usb_joy_1 = 16'h0200;
		step(2);
		compare_players(tx_word_0, tx_word_1, usb_joy_0, usb_joy_1, 1'b0, 8'h00);
		check_pause(2'b10);
		usb_joy_1 = '0;
		step(2);
		compare_players(tx_word_0, tx_word_1, usb_joy_0, usb_joy_1, 1'b0, 8'h00);
		check_pause(2'b00);
		end_test;

		total = err_cnt + cmp_err_cnt;
		$display("Tests: %0d, checks: %0d, errors: %0d", test_num, chk_cnt + cmp_cnt, total);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: sources.f
hdl/ctrl_pkg.sv
hdl/db15_reader.sv
hdl/player_mapper.sv
hdl/cabinet_regs.sv
hdl/ctrl_top.sv
dv/ctrl_tb_sva.sv
dv/ctrl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the control front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=ctrl_sim

verilator --binary --timing --assert -f sources.f --top-module ctrl_tb -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi
